/* regwin.f */
+incdir+tb
design/regwin_pkg.sv
design/window_addr_map.sv
design/write_decode.sv
design/reg_bank.sv
design/read_port.sv
design/register_file.sv
tb/register_file_tb.sv

/* Bender.yml */
package:
  name: regwin

sources:
  - files:
      - design/regwin_pkg.sv
      - design/window_addr_map.sv
      - design/write_decode.sv
      - design/reg_bank.sv
      - design/read_port.sv
      - design/register_file.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/register_file_tb.sv

/* tb/regwin_model.svh */
/* Reference model of the windowed register file for the testbench.
   Included inside the testbench module after the package import. */

`ifndef REGWIN_MODEL_SVH
`define REGWIN_MODEL_SVH

	// Shadow copy of the physical registers
	word_t shadow [NUM_PHYS_REGS];

	// Globals stay put, windowed names wrap modulo 64 above the globals
	function automatic int phys_of(input int w, input int r);
		int rot;
		if (r < NUM_GLOBALS) begin
			return r;
		end
		rot = WINDOW_STRIDE * w + r - WINDOW_STRIDE;
		rot = ((rot % (NUM_WINDOWS * WINDOW_STRIDE)) + NUM_WINDOWS * WINDOW_STRIDE)
			% (NUM_WINDOWS * WINDOW_STRIDE);
		return NUM_GLOBALS + rot;
	endfunction

	function automatic void reset_shadow();
		for (int i = 0; i < NUM_PHYS_REGS; i++) begin
			shadow[i] = '0;
		end
	endfunction

	// Clear beats enable, r0 never changes
	function automatic void apply_write(input int w, input wr_req_t req);
		int p;
		p = phys_of(w, int'(req.addr));
		if (p != 0) begin
			if (req.clr) begin
				shadow[p] = '0;
			end else if (req.en) begin
				shadow[p] = req.data;
			end
		end
	endfunction

	function automatic word_t expected_word(input int w, input int r);
		return shadow[phys_of(w, r)];
	endfunction

`endif

/* tb/register_file_tb.sv */
/* Self-checking testbench for the windowed register file.
   Drives writes, clears and reads and compares both ports with a model. */

`default_nettype none

module register_file_tb
	import regwin_pkg::*;
;

	localparam int CLK_PERIOD      = 20;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 256;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST + 100;

	logic      clk;
	logic      rst_n;
	window_t   current_window;
	wr_req_t   wr;
	reg_addr_t addr_a;
	reg_addr_t addr_b;
	word_t     data_a;
	word_t     data_b;

	integer seed;
	int     error_count;
	int     check_count;
	int     test_count;
	int     failed_tests;
	int     errors_before;

	`include "regwin_model.svh"

	register_file register_file_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.current_window (current_window),
		.wr             (wr),
		.addr_a         (addr_a),
		.addr_b         (addr_b),
		.data_a         (data_a),
		.data_b         (data_b)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

	function automatic wr_req_t write_req(input int a, input word_t d, input bit en, input bit clr);
		wr_req_t req;
		req.addr = reg_addr_t'(a);
		req.data = d;
		req.en   = en;
		req.clr  = clr;
		return req;
	endfunction

	task automatic check_port(input string name, input word_t actual, input word_t expected);
		check_count++;
		assert (actual === expected)
		else begin
			$display("Mismatch at time %0t: %s expected %h got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// One clock cycle: drive on the edge, check at the falling edge, then
	// let the model take the write that the DUT stores on the next edge
	task automatic run_cycle(input int w, input wr_req_t req, input int a, input int b);
		@(posedge clk);
		current_window <= window_t'(w);
		wr             <= req;
		addr_a         <= reg_addr_t'(a);
		addr_b         <= reg_addr_t'(b);
		@(negedge clk);
		check_port("data_a", data_a, expected_word(w, a));
		check_port("data_b", data_b, expected_word(w, b));
		apply_write(w, req);
	endtask

	task automatic read_cycle(input int w, input int a, input int b);
		run_cycle(w, write_req(0, '0, 1'b0, 1'b0), a, b);
	endtask

	task automatic start_test();
		errors_before = error_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count == errors_before) begin
			$display("Test %0d %s: ok", test_count, name);
		end else begin
			failed_tests++;
			$display("Test %0d %s: FAILED with %0d errors", test_count, name,
				error_count - errors_before);
		end
	endtask

	initial begin
		seed           = 32'ha880b3c0;
		error_count    = 0;
		check_count    = 0;
		test_count     = 0;
		failed_tests   = 0;
		errors_before  = 0;
		rst_n          = 1'b0;
		current_window = '0;
		wr             = '0;
		addr_a         = '0;
		addr_b         = '0;
		reset_shadow();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		start_test();
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int r = 0; r < 32; r++) begin
				read_cycle(w, r, 31 - r);
			end
		end
		end_test("reset_clears_all");

		// Old value in the write cycle, new value from the next one
		start_test();
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int k = 0; k < 4; k++) begin
				run_cycle(w, write_req(1 + 8 * k + w, $random(seed), 1'b1, 1'b0),
					1 + 8 * k + w, 1 + 8 * k + w);
				read_cycle(w, 1 + 8 * k + w, 1 + 8 * k + w);
			end
		end
		end_test("write_then_read");

		start_test();
		run_cycle(1, write_req(5, 32'h5a5a_0005, 1'b1, 1'b0), 5, 5);
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			read_cycle(w, 5, 5);
		end
		// Distinct local values per window expose any leak between windows
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int k = 0; k < 8; k++) begin
				run_cycle(w, write_req(16 + k, 32'ha000_0000 | (w << 8) | k, 1'b1, 1'b0),
					16 + k, 23 - k);
			end
		end
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int k = 0; k < 8; k++) begin
				read_cycle(w, 16 + k, 23 - k);
			end
		end
		end_test("globals_and_locals");

		// Outs of window w are the ins of window w-1
		start_test();
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int k = 0; k < 8; k++) begin
				run_cycle(w, write_req(8 + k, $random(seed), 1'b1, 1'b0), 8 + k, 24 + k);
				read_cycle((w + NUM_WINDOWS - 1) % NUM_WINDOWS, 24 + k, 24 + k);
			end
		end
		end_test("window_overlap");

		start_test();
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			run_cycle(w, write_req(0, 32'hdead_beef, 1'b1, 1'b0), 0, 0);
			read_cycle(w, 0, 0);
		end
		run_cycle(2, write_req(10, 32'h0000_0a0a, 1'b1, 1'b0), 10, 11);
		run_cycle(2, write_req(11, 32'h0000_0b0b, 1'b1, 1'b0), 10, 11);
		run_cycle(2, write_req(12, 32'h0000_0c0c, 1'b1, 1'b0), 11, 12);
		run_cycle(2, write_req(11, 32'hffff_ffff, 1'b0, 1'b1), 11, 12);
		read_cycle(2, 10, 11);
		read_cycle(2, 12, 11);
		run_cycle(2, write_req(13, 32'h0000_0d0d, 1'b1, 1'b0), 13, 12);
		run_cycle(2, write_req(13, 32'h1234_5678, 1'b1, 1'b1), 13, 13);
		read_cycle(2, 13, 13);
		end_test("r0_and_clear");

		start_test();
		for (int i = 0; i < 200; i++) begin
			run_cycle($unsigned($random(seed)) % NUM_WINDOWS,
				write_req($unsigned($random(seed)) % 32, $random(seed),
					$random(seed) & 1, ($unsigned($random(seed)) % 8) == 0),
				$unsigned($random(seed)) % 32, $unsigned($random(seed)) % 32);
		end
		end_test("random_traffic");

		$display("Tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/register_file.sv */
/* Top level of the windowed register file. Two combinational read ports,
   one synchronous write port with per-register clear, r0 fixed at zero. */

`default_nettype none

module register_file
	import regwin_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  window_t   current_window,
	input  wr_req_t   wr,
	input  reg_addr_t addr_a,
	input  reg_addr_t addr_b,
	output word_t     data_a,
	output word_t     data_b
);

	phys_mask_t                load_mask;
	phys_mask_t                clear_mask;
	word_t [NUM_PHYS_REGS-1:0] regs;

	// Write side
	write_decode write_decode_inst (
		.current_window (current_window),
		.wr             (wr),
		.load_mask      (load_mask),
		.clear_mask     (clear_mask)
	);

	reg_bank reg_bank_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_mask  (load_mask),
		.clear_mask (clear_mask),
		.wdata      (wr.data),
		.regs       (regs)
	);

	// Read side, both ports see the same window
	read_port port_a (
		.current_window (current_window),
		.addr           (addr_a),
		.regs           (regs),
		.data           (data_a)
	);

	read_port port_b (
		.current_window (current_window),
		.addr           (addr_b),
		.regs           (regs),
		.data           (data_b)
	);

endmodule

`default_nettype wire

/* design/read_port.sv */
/* One combinational read port. Resolves the logical address through the
   current window and returns the selected entry of the register bank. */

`default_nettype none

module read_port
	import regwin_pkg::*;
(
	input  window_t                   current_window,
	input  reg_addr_t                 addr,
	input  word_t [NUM_PHYS_REGS-1:0] regs,
	output word_t                     data
);

	phys_idx_t rd_phys;

	window_addr_map rd_map (
		.window   (current_window),
		.reg_addr (addr),
		.phys     (rd_phys)
	);

	// The mapped index never exceeds 71, so every select lands on a
	// real entry
	// No bypass from the write port, a write in this cycle shows up
	// only after the next edge
	assign data = regs[rd_phys];

endmodule

`default_nettype wire

/* design/reg_bank.sv */
/* Storage for the 72 physical registers with per-entry load and clear.
   Entry 0 is a constant zero and all other entries reset asynchronously. */

`default_nettype none

module reg_bank
	import regwin_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  phys_mask_t                    load_mask,
	input  phys_mask_t                    clear_mask,
	input  word_t                         wdata,
	output word_t [NUM_PHYS_REGS-1:0]     regs
);

	// Real flops only for entries 1 to 71
	word_t [NUM_PHYS_REGS-1:1] store;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			store <= '0;
		end else begin
			for (int i = 1; i < NUM_PHYS_REGS; i++) begin
				// Clear and load never arrive together from the decoder,
				// but clear still wins here if they ever do
				if (clear_mask[i]) begin
					store[i] <= '0;
				end else if (load_mask[i]) begin
					store[i] <= wdata;
				end
			end
		end
	end

	// Bit 0 of the masks has nothing to act on, so logical r0 stays zero
	// in every window without any special casing upstream
	assign regs = {store, word_t'('0)};

endmodule

`default_nettype wire

/* design/write_decode.sv */
/* Decodes a write request into one-hot load and clear masks over the
   physical registers, using the current window to locate the target. */

`default_nettype none

module write_decode
	import regwin_pkg::*;
(
	input  window_t    current_window,
	input  wr_req_t    wr,
	output phys_mask_t load_mask,
	output phys_mask_t clear_mask
);

	phys_idx_t wr_phys;

	// Same mapping as the read side, so a write and a later read of the
	// same logical name in the same window always meet
	window_addr_map wr_map (
		.window   (current_window),
		.reg_addr (wr.addr),
		.phys     (wr_phys)
	);

	// At most one bit set across both masks
	// Clear beats enable when both strobes are high
	always_comb begin
		load_mask  = '0;
		clear_mask = '0;
		if (wr.clr) begin
			clear_mask[wr_phys] = 1'b1;
		end else if (wr.en) begin
			load_mask[wr_phys] = 1'b1;
		end
	end

	// A write to r0 still raises bit 0 here
	// the bank has no storage behind that bit so it goes nowhere

endmodule

`default_nettype wire

/* design/window_addr_map.sv */
/* Maps a logical register number in the current window to a physical index.
   Shared by the write decoder and both read ports. */

`default_nettype none

module window_addr_map
	import regwin_pkg::*;
(
	input  window_t   window,
	input  reg_addr_t reg_addr,
	output phys_idx_t phys
);

	logic      is_global;
	logic      [SLOT_W-1:0] slot;
	phys_idx_t windowed_phys;

	// r0 to r7 are the same registers in every window
	assign is_global = (reg_addr < reg_addr_t'(NUM_GLOBALS));

	// Position inside the rotating region, (16*w + r - 16) mod 64
	// The modulo is free since the region size is a power of two and
	// the slot counter simply wraps
	assign slot = SLOT_W'(WINDOW_STRIDE * window)
		+ SLOT_W'(reg_addr)
		- SLOT_W'(WINDOW_STRIDE);

	// Windowed registers sit right above the globals
	assign windowed_phys = phys_idx_t'(NUM_GLOBALS) + phys_idx_t'(slot);

	// Resulting layout for reference
	//   window 0  outs 64-71  locals 8-15   ins 16-23
	//   window 1  outs 16-23  locals 24-31  ins 32-39
	//   window 2  outs 32-39  locals 40-47  ins 48-55
	//   window 3  outs 48-55  locals 56-63  ins 64-71
	assign phys = is_global ? phys_idx_t'(reg_addr) : windowed_phys;

endmodule

`default_nettype wire

/* design/regwin_pkg.sv */
/* Shared sizes and types for the windowed register file.
   Imported by every RTL module and by the testbench. */

`default_nettype none

package regwin_pkg;

	// Data path width
	localparam int WORD_W = 32;

	// Logical view seen by one window
	localparam int NUM_LOGICAL_REGS = 32;
	localparam int REG_ADDR_W = $clog2(NUM_LOGICAL_REGS);

	// Window organisation
	localparam int NUM_WINDOWS = 4;
	localparam int WINDOW_W = $clog2(NUM_WINDOWS);
	localparam int NUM_GLOBALS = 8;

	// Consecutive windows are shifted by this many physical registers,
	// so the outs of one window land on the ins of the next lower one
	localparam int WINDOW_STRIDE = 16;

	// Registers above the globals that rotate with the window
	localparam int WINDOWED_REGS = NUM_WINDOWS * WINDOW_STRIDE;

	// Wrap counter width for the windowed region, 64 entries
	localparam int SLOT_W = $clog2(WINDOWED_REGS);

	// 8 globals plus 64 windowed registers
	localparam int NUM_PHYS_REGS = NUM_GLOBALS + WINDOWED_REGS;
	localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REGS);

	typedef logic [WORD_W-1:0]        word_t;
	typedef logic [REG_ADDR_W-1:0]    reg_addr_t;
	typedef logic [WINDOW_W-1:0]      window_t;
	typedef logic [PHYS_IDX_W-1:0]    phys_idx_t;

	// One bit per physical register
	typedef logic [NUM_PHYS_REGS-1:0] phys_mask_t;

	// Write port request, sampled on every rising clock edge
	typedef struct packed {
		reg_addr_t addr;
		word_t     data;
		logic      en;
		logic      clr;
	} wr_req_t;

endpackage

`default_nettype wire
